//--- verilog/priv_pkg.sv
package priv_pkg;

   ////////////////////////////////////////////////////////////
   // basic types
   ////////////////////////////////////////////////////////////

   typedef logic [31:0] xlen_t;
   typedef logic [11:0] csr_addr_t;

   // encodings follow mstatus.mpp
   typedef enum logic [1:0] {
      MODE_U = 2'd0,
      MODE_M = 2'd3
   } priv_mode_t;

   // low two bits of the csrrw/csrrs/csrrc funct3
   typedef enum logic [1:0] {
      CSR_RW = 2'd1,
      CSR_RS = 2'd2,
      CSR_RC = 2'd3
   } csr_op_t;

   typedef enum logic [1:0] {
      CTRL_RUN  = 2'd0,
      CTRL_TRAP = 2'd1,
      CTRL_RET  = 2'd2
   } ctrl_state_t;

   ////////////////////////////////////////////////////////////
   // machine CSR addresses
   ////////////////////////////////////////////////////////////

   localparam csr_addr_t CSR_MSTATUS  = 12'h300;
   localparam csr_addr_t CSR_MISA     = 12'h301;
   localparam csr_addr_t CSR_MIE      = 12'h304;
   localparam csr_addr_t CSR_MTVEC    = 12'h305;
   localparam csr_addr_t CSR_MSCRATCH = 12'h340;
   localparam csr_addr_t CSR_MEPC     = 12'h341;
   localparam csr_addr_t CSR_MCAUSE   = 12'h342;
   localparam csr_addr_t CSR_MTVAL    = 12'h343;
   localparam csr_addr_t CSR_MIP      = 12'h344;
   localparam csr_addr_t CSR_MHARTID  = 12'hf14;

   ////////////////////////////////////////////////////////////
   // mstatus fields and write masks
   ////////////////////////////////////////////////////////////

   localparam int MSTATUS_MIE_BIT  = 3;
   localparam int MSTATUS_MPIE_BIT = 7;
   // mpp sits at bits 12:11
   localparam int MSTATUS_MPP_LO   = 11;

   localparam xlen_t MSTATUS_WMASK = 32'h0000_1888;
   // meie, mtie, msie
   localparam xlen_t MIE_WMASK     = 32'h0000_0888;
   // only msip is software writable
   localparam xlen_t MIP_WMASK     = 32'h0000_0008;

   ////////////////////////////////////////////////////////////
   // cause codes
   ////////////////////////////////////////////////////////////

   localparam logic [4:0] IRQ_MSI = 5'd3;
   localparam logic [4:0] IRQ_MTI = 5'd7;
   localparam logic [4:0] IRQ_MEI = 5'd11;

   localparam logic [4:0] CAUSE_ILLEGAL = 5'd2;

endpackage

//--- verilog/trap_if.sv
`timescale 1ns/100ps

interface trap_if;
   import priv_pkg::*;

   // trap controller side
   logic       take_trap;
   logic       take_mret;
   xlen_t      trap_cause;
   xlen_t      trap_epc;
   xlen_t      trap_tval;
   priv_mode_t mode;

   // CSR file side
   logic       illegal;
   xlen_t      mtvec;
   xlen_t      mepc;
   logic       mstatus_mie;
   logic       mstatus_mpie;
   priv_mode_t mpp;
   xlen_t      irq_pending;

   modport ctrl (
      output take_trap, take_mret, trap_cause, trap_epc, trap_tval, mode,
      input  illegal, mtvec, mepc, mstatus_mie, mstatus_mpie, mpp, irq_pending
   );

   modport csrs (
      input  take_trap, take_mret, trap_cause, trap_epc, trap_tval, mode,
      output illegal, mtvec, mepc, mstatus_mie, mstatus_mpie, mpp, irq_pending
   );

endinterface

//--- verilog/csr_file.sv
`timescale 1ns/100ps

module csr_file #(
   parameter priv_pkg::xlen_t HART_ID    = 32'h0,
   parameter priv_pkg::xlen_t MISA_VALUE = 32'h4000_1100
) (
   input  logic                clk,
   input  logic                rstn,

   input  logic                csr_valid,
   input  priv_pkg::csr_op_t   csr_op,
   input  priv_pkg::csr_addr_t csr_addr,
   input  priv_pkg::xlen_t     csr_wdata,
   output logic                csr_done,
   output priv_pkg::xlen_t     csr_rdata,

   input  logic                ext_intr,
   input  logic                timer_intr,

   trap_if.csrs                tif
);
   import priv_pkg::*;

   ////////////////////////////////////////////////////////////
   // storage
   ////////////////////////////////////////////////////////////

   xlen_t mstatus;
   xlen_t mie;
   xlen_t mip_sw;
   xlen_t mtvec;
   xlen_t mscratch;
   xlen_t mepc;
   xlen_t mcause;
   xlen_t mtval;

   // hardware lines merged with the software bit
   xlen_t mip;

   xlen_t rd_val;
   xlen_t wr_val;
   logic  known;
   logic  op_writes;
   logic  illegal;
   logic  csr_we;

   function automatic xlen_t mstatus_wr(input xlen_t old_val, input xlen_t new_val);
      xlen_t res;
      res = (old_val & ~MSTATUS_WMASK) | (new_val & MSTATUS_WMASK);
      // only M and U exist, any nonzero mpp means M
      if (res[MSTATUS_MPP_LO +: 2] != 2'b00) begin
         res[MSTATUS_MPP_LO +: 2] = MODE_M;
      end
      return res;
   endfunction

   always_comb begin
      mip = mip_sw;
      mip[IRQ_MEI] = ext_intr;
      mip[IRQ_MTI] = timer_intr;
   end

   ////////////////////////////////////////////////////////////
   // read mux and legality
   ////////////////////////////////////////////////////////////

   always_comb begin
      known = 1'b1;
      case (csr_addr)
         CSR_MSTATUS:  rd_val = mstatus;
         CSR_MISA:     rd_val = MISA_VALUE;
         CSR_MIE:      rd_val = mie;
         CSR_MTVEC:    rd_val = mtvec;
         CSR_MSCRATCH: rd_val = mscratch;
         CSR_MEPC:     rd_val = mepc;
         CSR_MCAUSE:   rd_val = mcause;
         CSR_MTVAL:    rd_val = mtval;
         CSR_MIP:      rd_val = mip;
         CSR_MHARTID:  rd_val = HART_ID;
         default: begin
            rd_val = '0;
            known  = 1'b0;
         end
      endcase
   end

   // set and clear with a zero operand leave the CSR alone
   assign op_writes = (csr_op == CSR_RW) || (csr_wdata != '0);

   always_comb begin
      case (csr_op)
         CSR_RS:  wr_val = rd_val | csr_wdata;
         CSR_RC:  wr_val = rd_val & ~csr_wdata;
         default: wr_val = csr_wdata;
      endcase
   end

   // addr[11:10] == 3 marks a read-only CSR
   assign illegal = csr_valid &&
                    (!known ||
                     (csr_addr[11:10] == 2'b11 && op_writes) ||
                     tif.mode == MODE_U);

   assign csr_we = csr_valid && !illegal && op_writes;

   ////////////////////////////////////////////////////////////
   // response
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rstn) begin
         csr_done <= 1'b0;
      end else begin
         csr_done <= csr_valid && !illegal;
      end
   end

   // old value goes back to the core
   always_ff @(posedge clk) begin
      if (csr_valid) begin
         csr_rdata <= rd_val;
      end
   end

   ////////////////////////////////////////////////////////////
   // updates from software, traps and mret
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rstn) begin
         mstatus  <= '0;
         mie      <= '0;
         mip_sw   <= '0;
         mtvec    <= '0;
         mscratch <= '0;
         mepc     <= '0;
         mcause   <= '0;
         mtval    <= '0;
      end else begin
         if (csr_we) begin
            case (csr_addr)
               CSR_MSTATUS:  mstatus  <= mstatus_wr(mstatus, wr_val);
               CSR_MIE:      mie      <= (mie & ~MIE_WMASK) | (wr_val & MIE_WMASK);
               CSR_MIP:      mip_sw   <= wr_val & MIP_WMASK;
               CSR_MSCRATCH: mscratch <= wr_val;
               CSR_MEPC:     mepc     <= wr_val;
               CSR_MCAUSE:   mcause   <= wr_val;
               CSR_MTVAL:    mtval    <= wr_val;
               CSR_MTVEC: begin
                  // modes 2 and 3 are reserved
                  if (!wr_val[1]) begin
                     mtvec <= wr_val;
                  end
               end
               default: ;
            endcase
         end

         if (tif.take_trap) begin
            mstatus[MSTATUS_MPP_LO +: 2]  <= tif.mode;
            mstatus[MSTATUS_MPIE_BIT]     <= mstatus[MSTATUS_MIE_BIT];
            mstatus[MSTATUS_MIE_BIT]      <= 1'b0;
            mepc   <= tif.trap_epc;
            mcause <= tif.trap_cause;
            mtval  <= tif.trap_tval;
         end else if (tif.take_mret) begin
            mstatus[MSTATUS_MIE_BIT]      <= tif.mstatus_mpie;
            mstatus[MSTATUS_MPIE_BIT]     <= 1'b1;
            mstatus[MSTATUS_MPP_LO +: 2]  <= MODE_U;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // towards the trap controller
   ////////////////////////////////////////////////////////////

   assign tif.illegal      = illegal;
   assign tif.mtvec        = mtvec;
   assign tif.mepc         = mepc;
   assign tif.mstatus_mie  = mstatus[MSTATUS_MIE_BIT];
   assign tif.mstatus_mpie = mstatus[MSTATUS_MPIE_BIT];
   assign tif.mpp          = priv_mode_t'(mstatus[MSTATUS_MPP_LO +: 2]);
   assign tif.irq_pending  = mip & mie;

endmodule

//--- verilog/trap_ctrl.sv
`timescale 1ns/100ps

module trap_ctrl (
   input  logic                 clk,
   input  logic                 rstn,

   input  logic                 exc_valid,
   input  logic [4:0]           exc_cause,
   input  priv_pkg::xlen_t      exc_tval,
   input  logic                 mret_valid,
   input  logic                 instr_boundary,
   input  priv_pkg::xlen_t      pc,

   output logic                 redirect_valid,
   output priv_pkg::xlen_t      redirect_pc,
   output priv_pkg::priv_mode_t cpu_mode,

   trap_if.ctrl                 tif
);
   import priv_pkg::*;

   ctrl_state_t state;
   priv_mode_t  mode_q;

   logic       in_run;
   logic       irq_en;
   logic       irq_take;
   logic [4:0] irq_code;
   logic       mret_bad;
   logic       mret_ok;
   logic       trap_req;
   logic       mret_req;
   xlen_t      cause;
   xlen_t      tvec_base;
   xlen_t      target;

   assign in_run = (state == CTRL_RUN);

   ////////////////////////////////////////////////////////////
   // interrupt arbitration
   ////////////////////////////////////////////////////////////

   // U mode always takes M-level interrupts
   assign irq_en = (mode_q == MODE_U) || tif.mstatus_mie;

   always_comb begin
      if (tif.irq_pending[IRQ_MEI]) begin
         irq_code = IRQ_MEI;
      end else if (tif.irq_pending[IRQ_MSI]) begin
         irq_code = IRQ_MSI;
      end else begin
         irq_code = IRQ_MTI;
      end
   end

   assign irq_take = instr_boundary && irq_en && (tif.irq_pending != '0);

   ////////////////////////////////////////////////////////////
   // event decode
   ////////////////////////////////////////////////////////////

   assign mret_bad = mret_valid && (mode_q == MODE_U);
   assign mret_ok  = mret_valid && (mode_q == MODE_M);

   assign trap_req = in_run && (exc_valid || tif.illegal || mret_bad || irq_take);
   assign mret_req = in_run && mret_ok;

   always_comb begin
      if (exc_valid) begin
         cause = {27'b0, exc_cause};
      end else if (irq_take) begin
         cause = {1'b1, 26'b0, irq_code};
      end else begin
         // illegal CSR access or mret from U
         cause = {27'b0, CAUSE_ILLEGAL};
      end
   end

   assign tif.take_trap  = trap_req;
   assign tif.take_mret  = mret_req;
   assign tif.trap_cause = cause;
   assign tif.trap_epc   = pc;
   assign tif.trap_tval  = exc_valid ? exc_tval : '0;
   assign tif.mode       = mode_q;

   ////////////////////////////////////////////////////////////
   // redirect target
   ////////////////////////////////////////////////////////////

   assign tvec_base = {tif.mtvec[31:2], 2'b00};

   always_comb begin
      if (mret_req) begin
         target = tif.mepc;
      end else if (irq_take && tif.mtvec[1:0] == 2'b01) begin
         // vectored mode, base + 4 * code
         target = tvec_base + {25'b0, irq_code, 2'b00};
      end else begin
         target = tvec_base;
      end
   end

   always_ff @(posedge clk) begin
      if (trap_req || mret_req) begin
         redirect_pc <= target;
      end
   end

   ////////////////////////////////////////////////////////////
   // sequencing FSM and privilege mode
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rstn) begin
         state  <= CTRL_RUN;
         mode_q <= MODE_M;
      end else begin
         case (state)
            CTRL_RUN: begin
               if (trap_req) begin
                  state  <= CTRL_TRAP;
                  mode_q <= MODE_M;
               end else if (mret_req) begin
                  state  <= CTRL_RET;
                  mode_q <= tif.mpp;
               end
            end
            // single cycle, redirect is out
            default: state <= CTRL_RUN;
         endcase
      end
   end

   assign redirect_valid = (state != CTRL_RUN);
   assign cpu_mode       = mode_q;

endmodule

//--- verilog/priv_unit.sv
`timescale 1ns/100ps

module priv_unit #(
   parameter priv_pkg::xlen_t HART_ID    = 32'h0,
   parameter priv_pkg::xlen_t MISA_VALUE = 32'h4000_1100
) (
   input  logic                 clk,
   input  logic                 rstn,

   // CSR access
   input  logic                 csr_valid,
   input  priv_pkg::csr_op_t    csr_op,
   input  priv_pkg::csr_addr_t  csr_addr,
   input  priv_pkg::xlen_t      csr_wdata,
   output logic                 csr_done,
   output priv_pkg::xlen_t      csr_rdata,

   // exception and return
   input  logic                 exc_valid,
   input  logic [4:0]           exc_cause,
   input  priv_pkg::xlen_t      exc_tval,
   input  logic                 mret_valid,
   input  priv_pkg::xlen_t      pc,

   // interrupt lines
   input  logic                 ext_intr,
   input  logic                 timer_intr,
   input  logic                 instr_boundary,

   // towards fetch
   output logic                 redirect_valid,
   output priv_pkg::xlen_t      redirect_pc,
   output priv_pkg::priv_mode_t cpu_mode
);

   trap_if tif ();

   ////////////////////////////////////////////////////////////
   // CSR storage
   ////////////////////////////////////////////////////////////

   csr_file #(
      .HART_ID    (HART_ID),
      .MISA_VALUE (MISA_VALUE)
   ) csr_file_i (
      .clk        (clk),
      .rstn       (rstn),
      .csr_valid  (csr_valid),
      .csr_op     (csr_op),
      .csr_addr   (csr_addr),
      .csr_wdata  (csr_wdata),
      .csr_done   (csr_done),
      .csr_rdata  (csr_rdata),
      .ext_intr   (ext_intr),
      .timer_intr (timer_intr),
      .tif        (tif.csrs)
   );

   ////////////////////////////////////////////////////////////
   // trap sequencing
   ////////////////////////////////////////////////////////////

   trap_ctrl trap_ctrl_i (
      .clk            (clk),
      .rstn           (rstn),
      .exc_valid      (exc_valid),
      .exc_cause      (exc_cause),
      .exc_tval       (exc_tval),
      .mret_valid     (mret_valid),
      .instr_boundary (instr_boundary),
      .pc             (pc),
      .redirect_valid (redirect_valid),
      .redirect_pc    (redirect_pc),
      .cpu_mode       (cpu_mode),
      .tif            (tif.ctrl)
   );

endmodule

//--- testbench/priv_unit_props.sv
`timescale 1ns/100ps

module priv_unit_props (
   input logic                  clk,
   input logic                  rstn,
   input logic                  csr_valid,
   input logic                  exc_valid,
   input logic                  mret_valid,
   input logic                  instr_boundary,
   input logic                  illegal,
   input logic                  csr_done,
   input logic                  redirect_valid,
   input priv_pkg::ctrl_state_t state
);
   import priv_pkg::*;

   // number of failed assertions
   int fail_count = 0;

   // redirect lasts exactly one cycle
   redirect_pulse: assert property (@(posedge clk) disable iff (rstn)
      redirect_valid |=> !redirect_valid)
   else begin
      $error("redirect_valid held for more than one cycle");
      fail_count++;
   end

   // an exception always passes through CTRL_TRAP
   exc_enters_trap: assert property (@(posedge clk) disable iff (rstn)
      exc_valid |=> state == CTRL_TRAP)
   else begin
      $error("exception did not move the trap controller to CTRL_TRAP");
      fail_count++;
   end

   events_exclusive: assert property (@(posedge clk) disable iff (rstn)
      $onehot0({csr_valid, exc_valid, mret_valid, instr_boundary}))
   else begin
      $error("more than one event in the same cycle");
      fail_count++;
   end

   legal_access_done: assert property (@(posedge clk) disable iff (rstn)
      csr_valid && !illegal |=> csr_done && !redirect_valid)
   else begin
      $error("legal CSR access without csr_done on the next cycle, or with a redirect");
      fail_count++;
   end

   illegal_access_trap: assert property (@(posedge clk) disable iff (rstn)
      csr_valid && illegal |=> redirect_valid && !csr_done)
   else begin
      $error("illegal CSR access without a redirect on the next cycle");
      fail_count++;
   end

   // outputs quiet right after reset
   reset_quiet: assert property (@(posedge clk)
      rstn |=> !csr_done && !redirect_valid)
   else begin
      $error("csr_done or redirect_valid high after reset");
      fail_count++;
   end

endmodule

bind priv_unit priv_unit_props props_i (
   .clk            (clk),
   .rstn           (rstn),
   .csr_valid      (csr_valid),
   .exc_valid      (exc_valid),
   .mret_valid     (mret_valid),
   .instr_boundary (instr_boundary),
   .illegal        (tif.illegal),
   .csr_done       (csr_done),
   .redirect_valid (redirect_valid),
   .state          (trap_ctrl_i.state)
);

//--- testbench/tb_priv_unit.sv
`timescale 1ns/100ps

module tb_priv_unit;
   import priv_pkg::*;

   localparam xlen_t HART_ID    = 32'h0;
   localparam xlen_t MISA_VALUE = 32'h4000_1100;

   localparam int CLK_PERIOD      = 4;
   localparam int NUM_TESTS       = 5;
   localparam int CYCLES_PER_TEST = 200;

   logic       clk = 1'b0;
   logic       rstn;
   logic       csr_valid;
   csr_op_t    csr_op;
   csr_addr_t  csr_addr;
   xlen_t      csr_wdata;
   logic       csr_done;
   xlen_t      csr_rdata;
   logic       exc_valid;
   logic [4:0] exc_cause;
   xlen_t      exc_tval;
   logic       mret_valid;
   xlen_t      pc;
   logic       ext_intr;
   logic       timer_intr;
   logic       instr_boundary;
   logic       redirect_valid;
   xlen_t      redirect_pc;
   priv_mode_t cpu_mode;

   priv_unit #(
      .HART_ID    (HART_ID),
      .MISA_VALUE (MISA_VALUE)
   ) priv_unit_i (.*);

   always #(CLK_PERIOD / 2) clk = ~clk;

   ////////////////////////////////////////////////////////////
   // failure handling and compare tasks
   ////////////////////////////////////////////////////////////

   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("TEST FAILED");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
      if (got !== exp) begin
         stop_with_failure($sformatf("mismatch %s got 0x%08h expected 0x%08h", name, got, exp));
      end
   endtask

   task automatic check_mode(input string name, input priv_mode_t got, input priv_mode_t exp);
      if (got !== exp) begin
         stop_with_failure($sformatf("mismatch %s got 0x%0h expected 0x%0h", name, got, exp));
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         stop_with_failure($sformatf("mismatch %s got 0x%0h expected 0x%0h", name, got, exp));
      end
   endtask

   // stop as soon as a bound assertion has failed
   always @(negedge clk) begin
      if (priv_unit_i.props_i.fail_count != 0) begin
         stop_with_failure("a bound timing assertion on the DUT failed");
      end
   end

   initial begin
      #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
      stop_with_failure("timeout, the tests did not finish in time");
   end

   ////////////////////////////////////////////////////////////
   // bus level tasks, all start and end on a falling edge
   ////////////////////////////////////////////////////////////

   task automatic csr_access(input csr_op_t op, input csr_addr_t addr, input xlen_t wdata,
                             output xlen_t old_val);
      csr_valid = 1'b1;
      csr_op    = op;
      csr_addr  = addr;
      csr_wdata = wdata;
      @(negedge clk);
      csr_valid = 1'b0;
      if (csr_done !== 1'b1) begin
         stop_with_failure($sformatf("no csr_done one cycle after access to CSR 0x%03h", addr));
      end
      old_val = csr_rdata;
   endtask

   // set with zero never writes
   task automatic csr_read(input csr_addr_t addr, output xlen_t val);
      csr_access(CSR_RS, addr, '0, val);
   endtask

   task automatic csr_write(input csr_addr_t addr, input xlen_t val);
      xlen_t unused;
      csr_access(CSR_RW, addr, val, unused);
   endtask

   task automatic illegal_access(input csr_op_t op, input csr_addr_t addr, input xlen_t epc);
      csr_valid = 1'b1;
      csr_op    = op;
      csr_addr  = addr;
      csr_wdata = '0;
      pc        = epc;
      @(negedge clk);
      csr_valid = 1'b0;
      check_bit("csr_done", csr_done, 1'b0);
   endtask

   task automatic raise_exception(input logic [4:0] cause, input xlen_t epc, input xlen_t tval);
      exc_valid = 1'b1;
      exc_cause = cause;
      exc_tval  = tval;
      pc        = epc;
      @(negedge clk);
      exc_valid = 1'b0;
   endtask

   task automatic issue_mret(input xlen_t epc);
      mret_valid = 1'b1;
      pc         = epc;
      @(negedge clk);
      mret_valid = 1'b0;
   endtask

   task automatic pulse_boundary(input xlen_t epc);
      instr_boundary = 1'b1;
      pc             = epc;
      @(negedge clk);
      instr_boundary = 1'b0;
   endtask

   // called one cycle after the event
   task automatic expect_redirect(input xlen_t target, input priv_mode_t mode);
      if (redirect_valid !== 1'b1) begin
         stop_with_failure("no redirect one cycle after the event");
      end
      check_word("redirect_pc", redirect_pc, target);
      check_mode("cpu_mode", cpu_mode, mode);
      @(negedge clk);
   endtask

   ////////////////////////////////////////////////////////////
   // directed tests
   ////////////////////////////////////////////////////////////

   task automatic reset_values();
      xlen_t v;
      check_mode("cpu_mode", cpu_mode, MODE_M);
      check_bit("csr_done", csr_done, 1'b0);
      check_bit("redirect_valid", redirect_valid, 1'b0);
      csr_read(CSR_MISA, v);
      check_word("misa", v, MISA_VALUE);
      csr_read(CSR_MHARTID, v);
      check_word("mhartid", v, HART_ID);
      csr_read(CSR_MSTATUS, v);
      check_word("mstatus", v, 32'h0);
      csr_read(CSR_MIE, v);
      check_word("mie", v, 32'h0);
      csr_read(CSR_MTVEC, v);
      check_word("mtvec", v, 32'h0);
   endtask

   task automatic csr_operations();
      xlen_t a;
      xlen_t b;
      xlen_t c;
      xlen_t v;
      xlen_t old_val;
      xlen_t tvec;
      a = $urandom();
      b = $urandom();
      c = $urandom();
      csr_access(CSR_RW, CSR_MSCRATCH, a, old_val);
      check_word("mscratch old", old_val, 32'h0);
      csr_access(CSR_RS, CSR_MSCRATCH, b, old_val);
      check_word("mscratch old", old_val, a);
      csr_access(CSR_RC, CSR_MSCRATCH, c, old_val);
      check_word("mscratch old", old_val, a | b);
      csr_read(CSR_MSCRATCH, v);
      check_word("mscratch", v, (a | b) & ~c);

      // mpp written as 1 must come back as M
      a = ($urandom() & ~32'h0000_1800) | 32'h0000_0800;
      csr_write(CSR_MSTATUS, a);
      csr_read(CSR_MSTATUS, v);
      check_word("mstatus", v, (a & 32'h0000_0088) | 32'h0000_1800);

      a = $urandom();
      csr_write(CSR_MIE, a);
      csr_read(CSR_MIE, v);
      check_word("mie", v, a & 32'h0000_0888);

      // mode 2 is reserved, the write is dropped
      tvec = $urandom() & 32'hffff_fffc;
      csr_write(CSR_MTVEC, tvec);
      csr_write(CSR_MTVEC, ($urandom() & 32'hffff_fffc) | 32'h2);
      csr_read(CSR_MTVEC, v);
      check_word("mtvec", v, tvec);
   endtask

   task automatic exception_entry();
      xlen_t tvec;
      xlen_t epc;
      xlen_t tval;
      xlen_t v;
      tvec = $urandom() & 32'hffff_fffc;
      epc  = $urandom() & 32'hffff_fffc;
      tval = $urandom();
      csr_write(CSR_MTVEC, tvec);
      // mie on, mpie off
      csr_write(CSR_MSTATUS, 32'h0000_0008);
      raise_exception(5'd5, epc, tval);
      expect_redirect(tvec, MODE_M);
      csr_read(CSR_MEPC, v);
      check_word("mepc", v, epc);
      csr_read(CSR_MCAUSE, v);
      check_word("mcause", v, 32'd5);
      csr_read(CSR_MTVAL, v);
      check_word("mtval", v, tval);
      csr_read(CSR_MSTATUS, v);
      check_mode("mstatus.mpp", priv_mode_t'(v[12:11]), MODE_M);
      check_bit("mstatus.mpie", v[7], 1'b1);
      check_bit("mstatus.mie", v[3], 1'b0);
   endtask

   task automatic mret_and_user_mode();
      xlen_t tvec;
      xlen_t ret_pc;
      xlen_t epc;
      xlen_t v;
      tvec   = $urandom() & 32'hffff_fffc;
      csr_write(CSR_MTVEC, tvec);
      ret_pc = $urandom() & 32'hffff_fffc;
      csr_write(CSR_MEPC, ret_pc);
      // mpie 1, mpp U, mie 0
      csr_write(CSR_MSTATUS, 32'h0000_0080);
      issue_mret($urandom() & 32'hffff_fffc);
      expect_redirect(ret_pc, MODE_U);

      epc = $urandom() & 32'hffff_fffc;
      illegal_access(CSR_RS, CSR_MSCRATCH, epc);
      expect_redirect(tvec, MODE_M);
      csr_read(CSR_MCAUSE, v);
      check_word("mcause", v, 32'd2);
      csr_read(CSR_MEPC, v);
      check_word("mepc", v, epc);
      // mie was 1 in U, so mpie holds it now
      csr_read(CSR_MSTATUS, v);
      check_bit("mstatus.mpie", v[7], 1'b1);
      check_bit("mstatus.mie", v[3], 1'b0);
      check_mode("mstatus.mpp", priv_mode_t'(v[12:11]), MODE_U);

      // mret from U is illegal too
      csr_write(CSR_MTVAL, $urandom() | 32'h1);
      csr_write(CSR_MEPC, ret_pc);
      csr_write(CSR_MSTATUS, 32'h0000_0080);
      issue_mret($urandom() & 32'hffff_fffc);
      expect_redirect(ret_pc, MODE_U);
      epc = $urandom() & 32'hffff_fffc;
      issue_mret(epc);
      expect_redirect(tvec, MODE_M);
      csr_read(CSR_MCAUSE, v);
      check_word("mcause", v, 32'd2);
      csr_read(CSR_MTVAL, v);
      check_word("mtval", v, 32'h0);
      csr_read(CSR_MEPC, v);
      check_word("mepc", v, epc);
   endtask

   task automatic interrupt_entry();
      xlen_t base;
      xlen_t epc;
      xlen_t v;
      base = $urandom() & 32'hffff_ff00;
      csr_write(CSR_MSTATUS, 32'h0);
      csr_write(CSR_MIE, 32'h0000_0080);
      timer_intr = 1'b1;
      // masked by mstatus.mie in M
      pulse_boundary($urandom() & 32'hffff_fffc);
      check_bit("redirect_valid", redirect_valid, 1'b0);

      csr_write(CSR_MTVEC, base | 32'h1);
      csr_write(CSR_MSTATUS, 32'h0000_0008);
      epc = $urandom() & 32'hffff_fffc;
      pulse_boundary(epc);
      expect_redirect(base + 32'd28, MODE_M);
      csr_read(CSR_MCAUSE, v);
      check_word("mcause", v, 32'h8000_0007);
      csr_read(CSR_MEPC, v);
      check_word("mepc", v, epc);
      csr_read(CSR_MTVAL, v);
      check_word("mtval", v, 32'h0);

      // external wins over timer
      ext_intr = 1'b1;
      csr_write(CSR_MIE, 32'h0000_0880);
      csr_write(CSR_MSTATUS, 32'h0000_0008);
      pulse_boundary($urandom() & 32'hffff_fffc);
      expect_redirect(base + 32'd44, MODE_M);
      csr_read(CSR_MCAUSE, v);
      check_word("mcause", v, 32'h8000_000b);
      ext_intr   = 1'b0;
      timer_intr = 1'b0;
   endtask

   ////////////////////////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////////////////////////

   initial begin
      void'($urandom(66));
      rstn           = 1'b1;
      csr_valid      = 1'b0;
      csr_op         = CSR_RW;
      csr_addr       = '0;
      csr_wdata      = '0;
      exc_valid      = 1'b0;
      exc_cause      = '0;
      exc_tval       = '0;
      mret_valid     = 1'b0;
      pc             = '0;
      ext_intr       = 1'b0;
      timer_intr     = 1'b0;
      instr_boundary = 1'b0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rstn = 1'b0;

      reset_values();
      csr_operations();
      exception_entry();
      mret_and_user_mode();
      interrupt_entry();

      @(negedge clk);
      if (priv_unit_i.props_i.fail_count == 0) begin
         $display("TEST OK");
         $finish;
      end else begin
         stop_with_failure("a bound timing assertion failed near the end of the run");
      end
   end

endmodule

//--- tb.f
verilog/priv_pkg.sv
verilog/trap_if.sv
verilog/csr_file.sv
verilog/trap_ctrl.sv
verilog/priv_unit.sv
testbench/priv_unit_props.sv
testbench/tb_priv_unit.sv
